// File: sim.f
+incdir+logic
logic/opcodes.sv
logic/control.sv
logic/aluUnit.sv
logic/registerFile.sv
logic/pcUnit.sv
logic/busInterface.sv
logic/cpuCore.sv
sim/busMemory.sv
sim/cpuTb.sv

// File: sim/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpuTb;

   localparam int NumInstr      = 400;
   localparam int TimeoutCycles = NumInstr * 8 + 50;

   typedef struct packed {
      opcodes::wordT addr;
      opcodes::wordT data;
      logic          write;
   } busCycleT;

   logic          Clock;
   logic          nReset;
   opcodes::wordT busIn;
   opcodes::wordT busOut;
   logic          busOe;
   logic          ale;
   logic          nMe;
   logic          nOe;
   logic          nWe;
   logic          enb;
   opcodes::wordT readData;
   logic          cycleValid;
   opcodes::wordT cycleAddr;
   opcodes::wordT cycleData;
   logic          cycleWrite;
   logic          strobeError;
   integer        seed;
   int            cycleCount;

   // Instruction level model state
   opcodes::wordT  regs [`REG_COUNT];
   opcodes::flagsT flags;
   opcodes::wordT  pc;
   opcodes::wordT  lr;

   cpuCore DUT (.Clock, .nReset, .BusIn(busIn), .BusOut(busOut), .BusOe(busOe), .Ale(ale),
      .nMe(nMe), .nOe(nOe), .nWe(nWe), .Enb(enb));

   busMemory memory (.Clock, .nReset, .BusOut(busOut), .BusOe(busOe), .Ale(ale), .nMe(nMe),
      .nOe(nOe), .nWe(nWe), .Enb(enb), .ReadData(readData), .BusIn(busIn),
      .CycleValid(cycleValid), .CycleAddr(cycleAddr), .CycleData(cycleData),
      .CycleWrite(cycleWrite), .StrobeError(strobeError));

   initial begin
      Clock = 1'b0;
      forever #5 Clock = ~Clock;
   end

   task automatic failRun();
      $display("Testbench failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (strobeError) begin
         $display("Bus strobe order violated, see the bus error above");
         failRun();
      end else if (cycleCount >= TimeoutCycles) begin
         $display("Timeout after %0d cycles, the core stopped finishing instructions",
                  cycleCount);
         failRun();
      end
   end

   function automatic opcodes::wordT randomWord();
      logic [31:0] raw;
      raw = $random(seed);
      return raw[15:0];
   endfunction

   // Mostly ALU ops, with memory, branch and jump mixed in
   function automatic opcodes::instrT randomInstr();
      opcodes::instrT ins;
      opcodes::wordT  word;
      int             pick;
      pick = randomWord() % 20;
      word = randomWord();
      ins  = word;
      case (pick)
         10, 11:     ins.op = opcodes::LD;
         12, 13, 14: ins.op = opcodes::ST;
         15, 16:     ins.op = opcodes::BR;
         17:         ins.op = opcodes::JAL;
         18:         ins.op = opcodes::RET;
         19:         ins.op = 5'h0D + {2'b00, word[10:8]};    // Unassigned codes
         default:    ins.op = {2'b00, word[13:11]};
      endcase
      return ins;
   endfunction

   function automatic logic branchTaken(input logic [2:0] cond);
      case (cond)
         opcodes::AL: return 1'b1;
         opcodes::EQ: return flags.z;
         opcodes::NE: return !flags.z;
         opcodes::CS: return flags.c;
         opcodes::CC: return !flags.c;
         opcodes::MI: return flags.n;
         opcodes::PL: return !flags.n;
         default:     return flags.v;
      endcase
   endfunction

   function automatic void executeAlu(input opcodes::instrT ins);
      opcodes::wordT a;
      opcodes::wordT b;
      opcodes::wordT res;
      logic [16:0]   wide;
      a = regs[ins.rd];
      case (ins.op)
         opcodes::ADDI, opcodes::ADCI: b = {{8{ins.low[7]}}, ins.low};
         opcodes::ADDIB:               b = {ins.low, 8'h00};
         default:                      b = regs[ins.low[7:5]];
      endcase
      case (ins.op)
         opcodes::AND, opcodes::OR: begin
            res     = (ins.op == opcodes::AND) ? (a & b) : (a | b);
            flags.c = 1'b0;
            flags.v = 1'b0;
         end
         opcodes::SUB: begin
            res     = a - b;
            flags.c = (a >= b);    // Set when no borrow
            flags.v = (a[15] != b[15]) && (res[15] != a[15]);
         end
         default: begin
            wide = {1'b0, a} + {1'b0, b};
            if ((ins.op == opcodes::ADC || ins.op == opcodes::ADCI) && flags.c)
               wide = wide + 17'd1;
            res     = wide[15:0];
            flags.c = wide[16];
            flags.v = (a[15] == b[15]) && (res[15] != a[15]);
         end
      endcase
      flags.z      = (res == 16'h0000);
      flags.n      = res[15];
      regs[ins.rd] = res;
   endfunction

   task automatic waitBusCycle(output busCycleT cyc);
      @(posedge Clock);
      while (!cycleValid)
         @(posedge Clock);
      cyc.addr  = cycleAddr;
      cyc.data  = cycleData;
      cyc.write = cycleWrite;
   endtask

   task automatic compareFetch(input opcodes::wordT expAddr, input busCycleT cyc);
      if (cyc.write !== 1'b0) begin
         $display("MISMATCH fetch write bit: expected %h, got %h", 1'b0, cyc.write);
         failRun();
      end else if (cyc.addr !== expAddr) begin
         $display("MISMATCH BusOut fetch address: expected %h, got %h", expAddr, cyc.addr);
         failRun();
      end
   endtask

   // On a read the data word comes from the responder itself
   task automatic compareData(input opcodes::wordT expAddr, input opcodes::wordT expData,
                              input logic expWrite, input busCycleT cyc);
      if (cyc.write !== expWrite) begin
         $display("MISMATCH data write bit: expected %h, got %h", expWrite, cyc.write);
         failRun();
      end else if (cyc.addr !== expAddr) begin
         $display("MISMATCH BusOut data address: expected %h, got %h", expAddr, cyc.addr);
         failRun();
      end else if (expWrite && cyc.data !== expData) begin
         $display("MISMATCH BusOut store data: expected %h, got %h", expData, cyc.data);
         failRun();
      end
   endtask

   task automatic runInstruction();
      opcodes::instrT ins;
      busCycleT       cyc;
      opcodes::wordT  loadWord;
      ins = randomInstr();
      @(negedge Clock);
      readData = ins;
      waitBusCycle(cyc);
      compareFetch(pc, cyc);
      case (ins.op)
         opcodes::ADD, opcodes::ADC, opcodes::SUB, opcodes::AND, opcodes::OR,
         opcodes::ADDI, opcodes::ADCI, opcodes::ADDIB: begin
            executeAlu(ins);
            pc = pc + 16'd1;
         end
         opcodes::LD: begin
            loadWord = randomWord();
            @(negedge Clock);
            readData = loadWord;
            waitBusCycle(cyc);
            compareData(regs[ins.low[7:5]], loadWord, 1'b0, cyc);
            regs[ins.rd] = loadWord;
            pc           = pc + 16'd1;
         end
         opcodes::ST: begin
            waitBusCycle(cyc);
            compareData(regs[ins.low[7:5]], regs[ins.rd], 1'b1, cyc);
            pc = pc + 16'd1;
         end
         opcodes::BR:
            pc = branchTaken(ins.rd) ? pc + 16'd1 + {{8{ins.low[7]}}, ins.low} : pc + 16'd1;
         opcodes::JAL: begin
            lr = pc + 16'd1;
            pc = regs[ins.rd];
         end
         opcodes::RET: pc = lr;
         default:      pc = pc + 16'd1;    // NOP
      endcase
   endtask

   initial begin
      seed       = 13508;
      nReset     = 1'b0;
      readData   = '0;
      cycleCount = 0;
      flags      = '0;
      pc         = `RESET_VECTOR;
      lr         = '0;
      for (int i = 0; i < `REG_COUNT; i++)
         regs[i] = '0;
      repeat (4) begin
         @(negedge Clock);
         if (ale !== 1'b0 || enb !== 1'b0 || nMe !== 1'b1 || nOe !== 1'b1 ||
             nWe !== 1'b1 || busOe !== 1'b0) begin
            $display("Bus strobes are not at their idle levels during reset");
            failRun();
         end
      end
      nReset = 1'b1;
      for (int n = 0; n < NumInstr; n++)
         runInstruction();
      // Last instruction ends at the next address phase
      @(negedge Clock);
      while (ale !== 1'b1)
         @(negedge Clock);
      @(posedge Clock);
      if (strobeError) begin
         $display("Bus strobe order violated, see the bus error above");
         failRun();
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule

// File: sim/busMemory.sv
`timescale 1ns/1ps

module busMemory (
   input  logic          Clock,
   input  logic          nReset,
   input  opcodes::wordT BusOut,
   input  logic          BusOe,
   input  logic          Ale,
   input  logic          nMe,
   input  logic          nOe,
   input  logic          nWe,
   input  logic          Enb,
   input  opcodes::wordT ReadData,    // Word returned by the next read
   output opcodes::wordT BusIn,
   output logic          CycleValid,
   output opcodes::wordT CycleAddr,
   output opcodes::wordT CycleData,
   output logic          CycleWrite,
   output logic          StrobeError
);

   int phase;    // Last bus phase seen, 0 when idle

   task flagError(input string what);
      $display("Bus strobe error at %0t ns: %s", $time, what);
      StrobeError <= 1'b1;
   endtask

   initial begin
      phase       = 0;
      BusIn       = '0;
      CycleValid  = 1'b0;
      CycleAddr   = '0;
      CycleData   = '0;
      CycleWrite  = 1'b0;
      StrobeError = 1'b0;
   end

   // Strobes settle after the rising edge, so look at them mid cycle
   always @(negedge Clock) begin
      CycleValid <= 1'b0;
      if (!nReset) begin
         phase = 0;
      end else if (Ale) begin
         if (phase != 0 || nMe || !nOe || !nWe || Enb || BusOe)
            flagError("Ale high outside a clean address phase");
         CycleAddr <= BusOut;
         phase = 1;
      end else if (phase == 1 || phase == 2) begin
         if (nMe || nOe == nWe)
            flagError("nMe high, or nOe and nWe not exclusive, in a data phase");
         if (BusOe != !nWe)
            flagError("BusOe does not match the write strobe");
         if (Enb != (phase == 2))
            flagError("Enb not confined to phase 3");
         if (phase == 2) begin
            CycleWrite <= !nWe;
            CycleData  <= nWe ? ReadData : BusOut;
            if (nWe)
               BusIn <= ReadData;    // Held up to the edge closing phase 3
         end
         phase = phase + 1;
      end else begin
         if (!nMe || !nOe || !nWe || Enb || BusOe)
            flagError(phase == 3 ? "Strobes still active in phase 4" :
                      "Strobes active outside a bus cycle");
         if (phase == 3)
            CycleValid <= 1'b1;
         BusIn <= '0;
         phase = 0;
      end
   end

endmodule

// File: logic/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
   input  logic          Clock,
   input  logic          nReset,
   input  opcodes::wordT BusIn,
   output opcodes::wordT BusOut,
   output logic          BusOe,
   output logic          Ale,
   output logic          nMe,
   output logic          nOe,
   output logic          nWe,
   output logic          Enb
);

   opcodes::ctrlWordT ctrl;
   opcodes::busPinsT  pins;
   opcodes::instrT    instr;
   opcodes::flagsT    flags;
   opcodes::wordT     aluResult;
   opcodes::wordT     loadData;
   opcodes::wordT     rd1;
   opcodes::wordT     rd2;
   opcodes::wordT     pc;

   assign Ale = pins.ale;
   assign nMe = pins.nMe;
   assign nOe = pins.nOe;
   assign nWe = pins.nWe;
   assign Enb = pins.enb;

   control uControl (.Clock, .nReset, .Instr(instr), .Flags(flags), .Ctrl(ctrl), .Pins(pins));

   aluUnit uAlu (.Clock, .nReset, .Ctrl(ctrl), .Rd1(rd1), .Rd2(rd2), .Imm(instr.low),
      .Result(aluResult), .Flags(flags));

   registerFile uRegs (.Clock, .nReset, .Ctrl(ctrl), .Instr(instr), .AluResult(aluResult),
      .LoadData(loadData), .Rd1(rd1), .Rd2(rd2));

   // JAL jumps through rd
   pcUnit uPc (.Clock, .nReset, .Ctrl(ctrl), .Instr(instr), .RegValue(rd1), .Pc(pc));

   // Memory address from rs, store data from rd
   busInterface uBus (.Clock, .nReset, .Ctrl(ctrl), .Pc(pc), .RegAddr(rd2), .StoreData(rd1),
      .BusIn, .BusOut, .BusOe, .Instr(instr), .LoadData(loadData));

endmodule

// File: logic/busInterface.sv
`timescale 1ns/1ps

module busInterface (
   input  logic              Clock,
   input  logic              nReset,
   input  opcodes::ctrlWordT Ctrl,
   input  opcodes::wordT     Pc,
   input  opcodes::wordT     RegAddr,
   input  opcodes::wordT     StoreData,
   input  opcodes::wordT     BusIn,
   output opcodes::wordT     BusOut,
   output logic              BusOe,
   output opcodes::instrT    Instr,
   output opcodes::wordT     LoadData
);

   // Address phase carries PC or rs, write phases the store data
   always_comb begin
      if (Ctrl.dataOe)
         BusOut = StoreData;
      else if (Ctrl.addrSel)
         BusOut = RegAddr;
      else
         BusOut = Pc;
   end

   assign BusOe = Ctrl.dataOe;

   // Instruction register
   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         Instr <= '0;
      else if (Ctrl.irWe)
         Instr <= opcodes::instrT'(BusIn);
   end

   always_ff @(posedge Clock) begin
      if (Ctrl.ldWe)
         LoadData <= BusIn;    // Sampled at the end of phase 3
   end

endmodule

// File: logic/pcUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pcUnit (
   input  logic              Clock,
   input  logic              nReset,
   input  opcodes::ctrlWordT Ctrl,
   input  opcodes::instrT    Instr,
   input  opcodes::wordT     RegValue,
   output opcodes::wordT     Pc
);

   opcodes::wordT pcPlus1;
   opcodes::wordT offset;
   opcodes::wordT nextPc;
   opcodes::wordT lr;    // Link register

   assign pcPlus1 = Pc + `WORD_BITS'(1);
   assign offset  = {{(`WORD_BITS-8){Instr.low[7]}}, Instr.low};

   always_comb begin
      case (Ctrl.pcSel)
         opcodes::PcRel: nextPc = pcPlus1 + offset;
         opcodes::PcReg: nextPc = RegValue;
         opcodes::PcLr:  nextPc = lr;
         default:        nextPc = pcPlus1;
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Pc <= `RESET_VECTOR;
         lr <= '0;
      end else begin
         if (Ctrl.pcWe)
            Pc <= nextPc;
         if (Ctrl.lrWe)
            lr <= pcPlus1;    // Return lands after the JAL
      end
   end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module registerFile (
   input  logic              Clock,
   input  logic              nReset,
   input  opcodes::ctrlWordT Ctrl,
   input  opcodes::instrT    Instr,
   input  opcodes::wordT     AluResult,
   input  opcodes::wordT     LoadData,
   output opcodes::wordT     Rd1,
   output opcodes::wordT     Rd2
);

   opcodes::wordT                regs [`REG_COUNT];
   opcodes::wordT                writeData;
   logic [$clog2(`REG_COUNT)-1:0] rs;

   assign rs = Instr.low[7:5];    // Source register field

   assign Rd1 = regs[Instr.rd];
   assign Rd2 = regs[rs];

   assign writeData = Ctrl.wdSel ? LoadData : AluResult;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (Ctrl.regWe) begin
         regs[Instr.rd] <= writeData;
      end
   end

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module aluUnit (
   input  logic              Clock,
   input  logic              nReset,
   input  opcodes::ctrlWordT Ctrl,
   input  opcodes::wordT     Rd1,
   input  opcodes::wordT     Rd2,
   input  logic [7:0]        Imm,
   output opcodes::wordT     Result,
   output opcodes::flagsT    Flags
);

   opcodes::wordT       op2;
   opcodes::wordT       addB;
   opcodes::wordT       aluOut;
   logic [`WORD_BITS:0] sum;
   logic                carryIn;
   logic                isSub;
   logic                isArith;

   always_comb begin
      case (Ctrl.op2Sel)
         opcodes::Op2Imm:   op2 = {{(`WORD_BITS-8){Imm[7]}}, Imm};
         opcodes::Op2ImmHi: op2 = {Imm, {(`WORD_BITS-8){1'b0}}};
         default:           op2 = Rd2;
      endcase
   end

   // One adder for all three, SUB as A + ~B + 1
   assign isSub   = (Ctrl.aluFn == opcodes::FnSub);
   assign isArith = isSub || Ctrl.aluFn == opcodes::FnAdd || Ctrl.aluFn == opcodes::FnAdc;
   assign addB    = isSub ? ~op2 : op2;
   assign carryIn = isSub || (Ctrl.aluFn == opcodes::FnAdc && Flags.c);
   assign sum     = {1'b0, Rd1} + {1'b0, addB} + {{`WORD_BITS{1'b0}}, carryIn};

   always_comb begin
      case (Ctrl.aluFn)
         opcodes::FnAnd: aluOut = Rd1 & op2;
         opcodes::FnOr:  aluOut = Rd1 | op2;
         opcodes::FnPass: aluOut = op2;
         default:        aluOut = sum[`WORD_BITS-1:0];
      endcase
   end

   assign Result = Ctrl.aluWe ? aluOut : '0;    // Quiet outside ALU cycles

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         Flags <= '0;
      end else if (Ctrl.flagWe) begin
         Flags.z <= (aluOut == '0);
         Flags.n <= aluOut[`WORD_BITS-1];
         // Carry is not-borrow on SUB
         Flags.c <= isArith && sum[`WORD_BITS];
         Flags.v <= isArith && (Rd1[`WORD_BITS-1] == addB[`WORD_BITS-1])
                    && (aluOut[`WORD_BITS-1] != Rd1[`WORD_BITS-1]);
      end
   end

endmodule

// File: logic/control.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control (
   input  logic              Clock,
   input  logic              nReset,
   input  opcodes::instrT    Instr,
   input  opcodes::flagsT    Flags,
   output opcodes::ctrlWordT Ctrl,
   output opcodes::busPinsT  Pins
);

   typedef enum logic {fetch, execute} stateT;
   typedef enum logic [$clog2(`BUS_PHASES)-1:0] {fet1, fet2, fet3, fet4} fetchSubT;
   typedef enum logic [$clog2(`BUS_PHASES)-1:0] {exe1, exe2, exe3, exe4} executeSubT;

   stateT           state;
   fetchSubT        fetchSub;
   executeSubT      executeSub;
   logic            running;    // Holds the bus idle for one clock out of reset
   opcodes::opcodeT opcode;
   logic            memOp;
   logic            condTrue;

   assign opcode = opcodes::opcodeT'(Instr.op);
   assign memOp  = (opcode == opcodes::LD) || (opcode == opcodes::ST);

   always_comb begin
      case (opcodes::condT'(Instr.rd))
         opcodes::AL: condTrue = 1'b1;
         opcodes::EQ: condTrue = Flags.z;
         opcodes::NE: condTrue = !Flags.z;
         opcodes::CS: condTrue = Flags.c;
         opcodes::CC: condTrue = !Flags.c;
         opcodes::MI: condTrue = Flags.n;
         opcodes::PL: condTrue = !Flags.n;
         default:     condTrue = Flags.v;    // VS
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         running    <= 1'b0;
         state      <= fetch;
         fetchSub   <= fet1;
         executeSub <= exe1;
      end else if (!running) begin
         running <= 1'b1;
      end else if (state == fetch) begin
         case (fetchSub)
            fet1: fetchSub <= fet2;
            fet2: fetchSub <= fet3;
            fet3: fetchSub <= fet4;
            default: begin
               state      <= execute;
               fetchSub   <= fet1;
               executeSub <= exe1;
            end
         endcase
      end else begin
         case (executeSub)
            exe1: begin
               if (memOp)
                  executeSub <= exe2;
               else
                  state <= fetch;    // Single cycle ops
            end
            exe2: executeSub <= exe3;
            exe3: executeSub <= exe4;
            default: state <= fetch;
         endcase
      end
   end

   always_comb begin
      Ctrl        = '0;
      Ctrl.aluFn  = opcodes::FnPass;
      Ctrl.op2Sel = opcodes::Op2Reg;
      Ctrl.pcSel  = opcodes::Pc1;
      Pins.ale    = 1'b0;
      Pins.nMe    = 1'b1;
      Pins.nOe    = 1'b1;
      Pins.nWe    = 1'b1;
      Pins.enb    = 1'b0;
      if (running && state == fetch) begin
         case (fetchSub)
            fet1: begin
               Pins.ale = 1'b1;    // PC on the bus
               Pins.nMe = 1'b0;
            end
            fet2: begin
               Pins.nMe = 1'b0;
               Pins.nOe = 1'b0;
            end
            fet3: begin
               Pins.nMe  = 1'b0;
               Pins.nOe  = 1'b0;
               Pins.enb  = 1'b1;
               Ctrl.irWe = 1'b1;
            end
            default: ;    // Bus released in phase 4
         endcase
      end else if (running) begin
         case (executeSub)
            exe1: begin
               case (opcode)
                  opcodes::ADD, opcodes::ADC, opcodes::SUB, opcodes::AND, opcodes::OR,
                  opcodes::ADDI, opcodes::ADCI, opcodes::ADDIB: begin
                     case (opcode)
                        opcodes::ADC, opcodes::ADCI: Ctrl.aluFn = opcodes::FnAdc;
                        opcodes::SUB:                Ctrl.aluFn = opcodes::FnSub;
                        opcodes::AND:                Ctrl.aluFn = opcodes::FnAnd;
                        opcodes::OR:                 Ctrl.aluFn = opcodes::FnOr;
                        default:                     Ctrl.aluFn = opcodes::FnAdd;
                     endcase
                     case (opcode)
                        opcodes::ADDI, opcodes::ADCI: Ctrl.op2Sel = opcodes::Op2Imm;
                        opcodes::ADDIB:               Ctrl.op2Sel = opcodes::Op2ImmHi;
                        default:                      Ctrl.op2Sel = opcodes::Op2Reg;
                     endcase
                     Ctrl.aluWe  = 1'b1;
                     Ctrl.flagWe = 1'b1;
                     Ctrl.regWe  = 1'b1;
                     Ctrl.pcWe   = 1'b1;
                  end
                  opcodes::LD, opcodes::ST: begin
                     Pins.ale     = 1'b1;    // Address phase from rs
                     Pins.nMe     = 1'b0;
                     Ctrl.addrSel = 1'b1;
                  end
                  opcodes::BR: begin
                     Ctrl.pcWe  = 1'b1;
                     Ctrl.pcSel = condTrue ? opcodes::PcRel : opcodes::Pc1;
                  end
                  opcodes::JAL: begin
                     Ctrl.lrWe  = 1'b1;
                     Ctrl.pcWe  = 1'b1;
                     Ctrl.pcSel = opcodes::PcReg;
                  end
                  opcodes::RET: begin
                     Ctrl.pcWe  = 1'b1;
                     Ctrl.pcSel = opcodes::PcLr;
                  end
                  default: Ctrl.pcWe = 1'b1;    // NOP
               endcase
            end
            exe2, exe3: begin
               Pins.nMe     = 1'b0;
               Pins.enb     = (executeSub == exe3);
               Ctrl.addrSel = 1'b1;
               if (opcode == opcodes::ST) begin
                  Pins.nWe    = 1'b0;
                  Ctrl.dataOe = 1'b1;
               end else begin
                  Pins.nOe  = 1'b0;
                  Ctrl.ldWe = (executeSub == exe3);
               end
            end
            default: begin
               Ctrl.regWe = (opcode == opcodes::LD);    // Write back from the latch
               Ctrl.wdSel = 1'b1;
               Ctrl.pcWe  = 1'b1;
            end
         endcase
      end
   end

endmodule

// File: logic/opcodes.sv
`include "cpu_consts.svh"

package opcodes;

   typedef logic [`WORD_BITS-1:0] wordT;

   // Unlisted codes run as a NOP
   typedef enum logic [4:0] {
      ADD   = 5'h00,
      ADC   = 5'h01,
      SUB   = 5'h02,
      AND   = 5'h03,
      OR    = 5'h04,
      ADDI  = 5'h05,
      ADCI  = 5'h06,
      ADDIB = 5'h07,
      LD    = 5'h08,
      ST    = 5'h09,
      BR    = 5'h0A,
      JAL   = 5'h0B,
      RET   = 5'h0C
   } opcodeT;

   typedef enum logic [2:0] {FnAdd, FnAdc, FnSub, FnAnd, FnOr, FnPass} aluFnT;

   typedef enum logic [1:0] {Op2Reg, Op2Imm, Op2ImmHi} op2SelT;

   typedef enum logic [1:0] {Pc1, PcRel, PcReg, PcLr} pcSelT;

   typedef enum logic [2:0] {AL, EQ, NE, CS, CC, MI, PL, VS} condT;

   typedef struct packed {
      logic [4:0] op;
      logic [2:0] rd;      // Condition code for BR
      logic [7:0] low;     // rs in [7:5], or imm8
   } instrT;

   typedef struct packed {
      logic c;
      logic z;
      logic n;
      logic v;
   } flagsT;

   typedef struct packed {
      aluFnT  aluFn;
      op2SelT op2Sel;
      logic   aluWe;
      logic   flagWe;
      logic   regWe;
      logic   wdSel;     // 1 selects load data
      logic   pcWe;
      pcSelT  pcSel;
      logic   lrWe;
      logic   irWe;
      logic   ldWe;
      logic   addrSel;   // 1 puts the register address on the bus
      logic   dataOe;
   } ctrlWordT;

   typedef struct packed {
      logic ale;
      logic nMe;
      logic nOe;
      logic nWe;
      logic enb;
   } busPinsT;

endpackage

// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and address width
`define WORD_BITS 16

// General purpose registers
`define REG_COUNT 8

// First fetch address
`define RESET_VECTOR 16'h0000

// Clock cycles per memory access
`define BUS_PHASES 4

`endif
